// ==== hw/xbar_config.svh ====
/* Crossbar router configuration */

`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// number of input ports.
`define XBAR_I_ELS 4

// number of output ports.
`define XBAR_O_ELS 4

// width of the flit data word.
`define XBAR_DATA_W 16

// destination field width, never narrower than one bit.
`define XBAR_DEST_W (($clog2(`XBAR_O_ELS) > 0) ? $clog2(`XBAR_O_ELS) : 1)

// width of an input index, used by the arbiter pointers.
`define XBAR_IDX_W (($clog2(`XBAR_I_ELS) > 0) ? $clog2(`XBAR_I_ELS) : 1)

`endif

// ==== hw/xbar_flit_pkg.sv ====
/* Crossbar flit types */

`include "xbar_config.svh"

package xbar_flit_pkg;

  ////////////////////////////////////////
  // flit fields
  ////////////////////////////////////////

  // output index a flit is routed to.
  typedef logic [`XBAR_DEST_W-1:0] dest_t;

  // payload word.
  typedef logic [`XBAR_DATA_W-1:0] data_t;

  // a single flit, destination in the upper bits.
  typedef struct packed {
    dest_t dest;
    data_t data;
  } flit_t;

  ////////////////////////////////////////
  // per-port flit vectors
  ////////////////////////////////////////

  // one flit per input port.
  typedef flit_t [`XBAR_I_ELS-1:0] flit_vec_t;

  // one flit per output port.
  typedef flit_t [`XBAR_O_ELS-1:0] oflit_vec_t;

endpackage

// ==== hw/xbar_ctrl_pkg.sv ====
/* Crossbar control types */

`include "xbar_config.svh"

package xbar_ctrl_pkg;

  // one bit per input port.
  typedef logic [`XBAR_I_ELS-1:0] in_mask_t;

  // one bit per output port.
  typedef logic [`XBAR_O_ELS-1:0] out_mask_t;

  // output-major, row j holds the inputs requesting output j.
  typedef in_mask_t [`XBAR_O_ELS-1:0] req_mat_t;

  // output-major, row j is one-hot on the input granted output j.
  typedef in_mask_t [`XBAR_O_ELS-1:0] grant_mat_t;

  // input index, used as the round-robin pointer.
  typedef logic [`XBAR_IDX_W-1:0] in_idx_t;

endpackage

// ==== hw/xbar_route_decode.sv ====
/* Crossbar route decode */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_route_decode (
  input  xbar_ctrl_pkg::in_mask_t  i_valid,
  input  xbar_flit_pkg::flit_vec_t i_flit,
  output xbar_ctrl_pkg::req_mat_t  o_req
);

  import xbar_ctrl_pkg::*;
  import xbar_flit_pkg::*;

  // input-major select rows, one-hot on the destination.
  out_mask_t [`XBAR_I_ELS-1:0] sel;

  ////////////////////////////////////////
  // destination decode
  ////////////////////////////////////////

  // a destination beyond the last output matches no column.
  always_comb begin
    for (int k = 0; k < `XBAR_I_ELS; k++) begin
      for (int j = 0; j < `XBAR_O_ELS; j++) begin
        sel[k][j] = i_valid[k] && (i_flit[k].dest == dest_t'(j));
      end
    end
  end

  ////////////////////////////////////////
  // transpose to output-major
  ////////////////////////////////////////

  always_comb begin
    for (int j = 0; j < `XBAR_O_ELS; j++) begin
      for (int k = 0; k < `XBAR_I_ELS; k++) begin
        o_req[j][k] = sel[k][j];
      end
    end
  end

endmodule

// ==== hw/xbar_rr_arbiter.sv ====
/* Round-robin arbiter */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_rr_arbiter (
  input  logic                    clk_i,
  input  logic                    i_rst_n,
  input  xbar_ctrl_pkg::in_mask_t i_req,
  input  logic                    i_accept,
  output xbar_ctrl_pkg::in_mask_t o_grant
);

  import xbar_ctrl_pkg::*;

  // input with the highest priority this cycle.
  in_idx_t ptr_q;
  // index of the input currently granted.
  in_idx_t grant_idx;
  in_idx_t ptr_next;

  ////////////////////////////////////////
  // rotating scan
  ////////////////////////////////////////

  // scan upward from the pointer and wrap, first request wins.
  always_comb begin : scan
    int unsigned idx;
    logic        found;
    o_grant   = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int unsigned off = 0; off < `XBAR_I_ELS; off++) begin
      idx = (int'(ptr_q) + off) % `XBAR_I_ELS;
      if (!found && i_req[idx]) begin
        o_grant[idx] = 1'b1;
        grant_idx    = in_idx_t'(idx);
        found        = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // pointer update
  ////////////////////////////////////////

  // next priority goes to the input after the one just served.
  assign ptr_next = (grant_idx == in_idx_t'(`XBAR_I_ELS - 1)) ? '0 : grant_idx + 1'b1;

  // only a completed transfer moves the pointer.
  always_ff @(posedge clk_i) begin
    if (!i_rst_n) begin
      ptr_q <= '0;
    end else if (i_accept) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// ==== hw/xbar_output_execute.sv ====
/* Crossbar output execute */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_output_execute (
  input  logic                      clk_i,
  input  logic                      i_rst_n,
  input  xbar_ctrl_pkg::req_mat_t   i_req,
  input  xbar_flit_pkg::flit_vec_t  i_flit,
  input  xbar_ctrl_pkg::out_mask_t  i_ready,
  output xbar_ctrl_pkg::out_mask_t  o_valid,
  output xbar_flit_pkg::oflit_vec_t o_flit,
  output xbar_ctrl_pkg::grant_mat_t o_grant,
  output xbar_ctrl_pkg::out_mask_t  o_accept
);

  import xbar_flit_pkg::*;

  localparam int FLIT_W = $bits(flit_t);

  ////////////////////////////////////////
  // per-output arbitration
  ////////////////////////////////////////

  for (genvar j = 0; j < `XBAR_O_ELS; j++) begin : g_out

    // any requester makes the output valid.
    assign o_valid[j]  = |i_req[j];
    assign o_accept[j] = o_valid[j] & i_ready[j];

    xbar_rr_arbiter u_arb (
      .clk_i    (clk_i),
      .i_rst_n  (i_rst_n),
      .i_req    (i_req[j]),
      .i_accept (o_accept[j]),
      .o_grant  (o_grant[j])
    );

  end

  ////////////////////////////////////////
  // flit multiplexing
  ////////////////////////////////////////

  // one-hot and-or select.
  // an idle output has no grant bit set, so its flit reads as zero.
  always_comb begin : flit_mux
    logic [FLIT_W-1:0] acc;
    for (int j = 0; j < `XBAR_O_ELS; j++) begin
      acc = '0;
      for (int k = 0; k < `XBAR_I_ELS; k++) begin
        acc = acc | (i_flit[k] & {FLIT_W{o_grant[j][k]}});
      end
      o_flit[j] = flit_t'(acc);
    end
  end

endmodule

// ==== hw/xbar_yumi_result.sv ====
/* Crossbar yumi result */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_yumi_result (
  input  xbar_ctrl_pkg::grant_mat_t i_grant,
  input  xbar_ctrl_pkg::out_mask_t  i_accept,
  output xbar_ctrl_pkg::in_mask_t   o_yumi
);

  import xbar_ctrl_pkg::*;

  // grants that completed a transfer, output-major.
  in_mask_t  [`XBAR_O_ELS-1:0] taken;
  // same, input-major.
  out_mask_t [`XBAR_I_ELS-1:0] taken_t;

  // keep a grant row only when its output transferred.
  always_comb begin
    for (int j = 0; j < `XBAR_O_ELS; j++) begin
      taken[j] = i_grant[j] & {`XBAR_I_ELS{i_accept[j]}};
    end
  end

  always_comb begin
    for (int k = 0; k < `XBAR_I_ELS; k++) begin
      for (int j = 0; j < `XBAR_O_ELS; j++) begin
        taken_t[k][j] = taken[j][k];
      end
    end
  end

  // a flit goes to one output, so at most one bit per row is set.
  always_comb begin
    for (int k = 0; k < `XBAR_I_ELS; k++) begin
      o_yumi[k] = |taken_t[k];
    end
  end

endmodule

// ==== hw/xbar_router.sv ====
/* Crossbar router top */

`timescale 1ns/100ps

module xbar_router (
  input  logic                      clk_i,
  input  logic                      i_rst_n,

  // input ports, valid and yumi.
  input  xbar_ctrl_pkg::in_mask_t   i_valid,
  input  xbar_flit_pkg::flit_vec_t  i_flit,
  output xbar_ctrl_pkg::in_mask_t   o_yumi,

  // output ports, valid and ready.
  input  xbar_ctrl_pkg::out_mask_t  i_ready,
  output xbar_ctrl_pkg::out_mask_t  o_valid,
  output xbar_flit_pkg::oflit_vec_t o_flit,
  output xbar_ctrl_pkg::grant_mat_t o_grant
);

  import xbar_ctrl_pkg::*;

  req_mat_t  req;
  out_mask_t accept;

  ////////////////////////////////////////
  // route decode
  ////////////////////////////////////////

  xbar_route_decode u_decode (
    .i_valid (i_valid),
    .i_flit  (i_flit),
    .o_req   (req)
  );

  ////////////////////////////////////////
  // output execute
  ////////////////////////////////////////

  xbar_output_execute u_execute (
    .clk_i    (clk_i),
    .i_rst_n  (i_rst_n),
    .i_req    (req),
    .i_flit   (i_flit),
    .i_ready  (i_ready),
    .o_valid  (o_valid),
    .o_flit   (o_flit),
    .o_grant  (o_grant),
    .o_accept (accept)
  );

  ////////////////////////////////////////
  // yumi result
  ////////////////////////////////////////

  xbar_yumi_result u_result (
    .i_grant  (o_grant),
    .i_accept (accept),
    .o_yumi   (o_yumi)
  );

endmodule

// ==== verification/xbar_checker.sv ====
/* Crossbar reference model and checker */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_checker (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  xbar_ctrl_pkg::in_mask_t   i_valid,
  input  xbar_flit_pkg::flit_vec_t  i_flit,
  input  xbar_ctrl_pkg::in_mask_t   i_yumi,
  input  xbar_ctrl_pkg::out_mask_t  i_ready,
  input  xbar_ctrl_pkg::out_mask_t  i_out_valid,
  input  xbar_flit_pkg::oflit_vec_t i_out_flit,
  input  xbar_ctrl_pkg::grant_mat_t i_out_grant,
  input  int                        i_test_id,
  input  logic                      i_test_end,
  output int                        o_pass_cnt,
  output int                        o_fail_cnt
);

  import xbar_ctrl_pkg::*;
  import xbar_flit_pkg::*;

  localparam int STARVE_LIMIT = `XBAR_I_ELS * 64;

  // model pointer per output holding the input with top priority.
  int ptr [`XBAR_O_ELS];
  // cycles each source has waited for its yumi.
  int wait_cnt [`XBAR_I_ELS];
  int err_cnt;
  int xfer_cnt;
  int yumi_cnt;
  int cyc_cnt;

  initial begin
    o_pass_cnt = 0;
    o_fail_cnt = 0;
    err_cnt    = 0;
    xfer_cnt   = 0;
    yumi_cnt   = 0;
    cyc_cnt    = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset and idle";
      2:       return "round-robin fairness";
      3:       return "uncontended routing";
      4:       return "back-pressure";
      5:       return "random traffic";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // per-cycle prediction
  ////////////////////////////////////////

  // outputs are settled at the falling edge and pointers move at the next rising edge.
  always @(negedge i_clk) begin : model
    in_mask_t  req;
    in_mask_t  exp_grant;
    in_mask_t  exp_yumi;
    out_mask_t exp_valid;
    flit_t     exp_flit;
    int        win;
    if (!i_rst_n) begin
      for (int j = 0; j < `XBAR_O_ELS; j++) ptr[j] = 0;
      for (int k = 0; k < `XBAR_I_ELS; k++) wait_cnt[k] = 0;
    end else begin
      cyc_cnt++;
      exp_valid = '0;
      exp_yumi  = '0;
      for (int j = 0; j < `XBAR_O_ELS; j++) begin
        req = '0;
        for (int k = 0; k < `XBAR_I_ELS; k++) begin
          if (i_valid[k] && int'(i_flit[k].dest) == j) req[k] = 1'b1;
        end
        // first requester at or after the pointer with wrap-around.
        win = -1;
        for (int off = 0; off < `XBAR_I_ELS; off++) begin
          if (win < 0 && req[(ptr[j] + off) % `XBAR_I_ELS]) win = (ptr[j] + off) % `XBAR_I_ELS;
        end
        exp_grant = '0;
        exp_flit  = '0;
        if (win >= 0) begin
          exp_valid[j]   = 1'b1;
          exp_grant[win] = 1'b1;
          exp_flit       = i_flit[win];
        end
        if (i_out_grant[j] !== exp_grant) begin
          report_mismatch($sformatf("o_grant[%0d]", j), 32'(exp_grant), 32'(i_out_grant[j]));
        end
        if (i_out_flit[j] !== exp_flit) begin
          report_mismatch($sformatf("o_flit[%0d]", j), 32'(exp_flit), 32'(i_out_flit[j]));
        end
        if (win >= 0 && i_ready[j]) begin
          exp_yumi[win] = 1'b1;
          ptr[j] = (win + 1) % `XBAR_I_ELS;
        end
      end
      if (i_out_valid !== exp_valid) report_mismatch("o_valid", 32'(exp_valid), 32'(i_out_valid));
      if (i_yumi !== exp_yumi) report_mismatch("o_yumi", 32'(exp_yumi), 32'(i_yumi));
      yumi_cnt += $countones(i_yumi);
      xfer_cnt += $countones(i_out_valid & i_ready);
      for (int k = 0; k < `XBAR_I_ELS; k++) begin
        if (i_valid[k] && !i_yumi[k]) begin
          wait_cnt[k]++;
          if (wait_cnt[k] == STARVE_LIMIT) begin
            $display("input %0d starved, no yumi after %0d cycles", k, STARVE_LIMIT);
            err_cnt++;
          end
        end else begin
          wait_cnt[k] = 0;
        end
      end
    end
    if (i_test_end) begin
      // every yumi must pair with exactly one transfer.
      if (yumi_cnt != xfer_cnt) begin
        $display("yumi count %0d does not match transfer count %0d", yumi_cnt, xfer_cnt);
        err_cnt++;
      end
      $display("test %0d %s: %0d cycles, %0d transfers, %0d errors, %s", i_test_id,
               test_name(i_test_id), cyc_cnt, xfer_cnt, err_cnt,
               (err_cnt == 0) ? "passed" : "failed");
      if (err_cnt == 0) o_pass_cnt++;
      else o_fail_cnt++;
      err_cnt  = 0;
      xfer_cnt = 0;
      yumi_cnt = 0;
      cyc_cnt  = 0;
    end
  end

endmodule

// ==== verification/xbar_tb.sv ====
/* Crossbar router testbench */

`timescale 1ns/100ps

`include "xbar_config.svh"

module xbar_tb;

  import xbar_ctrl_pkg::*;
  import xbar_flit_pkg::*;

  localparam int NUM_TESTS   = 5;
  // test lengths in cycles in run order.
  localparam int LEN_IDLE    = 20;
  localparam int LEN_FAIR    = 200;
  localparam int LEN_UNCONT  = 200;
  localparam int LEN_BACKP   = 300;
  localparam int LEN_RANDOM  = 2000;
  localparam int CYCLE_LIMIT =
    (LEN_IDLE + LEN_FAIR + LEN_UNCONT + LEN_BACKP + LEN_RANDOM) * 3 / 2;

  // how a source picks the destination of a new flit.
  localparam int DEST_RANDOM = 0;
  localparam int DEST_OWN    = 1;
  localparam int DEST_ZERO   = 2;

  logic       clk;
  logic       rst_n;
  in_mask_t   src_valid;
  flit_vec_t  src_flit;
  in_mask_t   yumi;
  out_mask_t  rcv_ready;
  out_mask_t  out_valid;
  oflit_vec_t out_flit;
  grant_mat_t out_grant;

  int   test_id;
  logic test_end;
  int   pass_cnt;
  int   fail_cnt;
  int   cycle_cnt;

  // traffic shape of the running test.
  int valid_pct;
  int ready_pct;
  int dest_mode;

  xbar_router i_xbar_router (
    .clk_i   (clk),
    .i_rst_n (rst_n),
    .i_valid (src_valid),
    .i_flit  (src_flit),
    .o_yumi  (yumi),
    .i_ready (rcv_ready),
    .o_valid (out_valid),
    .o_flit  (out_flit),
    .o_grant (out_grant)
  );

  xbar_checker u_checker (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_valid     (src_valid),
    .i_flit      (src_flit),
    .i_yumi      (yumi),
    .i_ready     (rcv_ready),
    .i_out_valid (out_valid),
    .i_out_flit  (out_flit),
    .i_out_grant (out_grant),
    .i_test_id   (test_id),
    .i_test_end  (test_end),
    .o_pass_cnt  (pass_cnt),
    .o_fail_cnt  (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // sources and receivers
  ////////////////////////////////////////

  function automatic dest_t pick_dest(input int k);
    case (dest_mode)
      DEST_OWN:  return dest_t'(k % `XBAR_O_ELS);
      DEST_ZERO: return '0;
      default:   return dest_t'($urandom % `XBAR_O_ELS);
    endcase
  endfunction

  // a source drops its flit on yumi and an idle source may raise a new one.
  task automatic update_sources(input in_mask_t taken);
    for (int k = 0; k < `XBAR_I_ELS; k++) begin
      if (src_valid[k] && taken[k]) begin
        src_valid[k] = 1'b0;
      end
      if (!src_valid[k] && (($urandom % 100) < valid_pct)) begin
        src_valid[k]     = 1'b1;
        src_flit[k].dest = pick_dest(k);
        src_flit[k].data = data_t'($urandom);
      end
    end
    for (int j = 0; j < `XBAR_O_ELS; j++) begin
      rcv_ready[j] = (($urandom % 100) < ready_pct);
    end
  endtask

  // yumi is sampled mid-cycle and inputs change 1 ns after the edge.
  task automatic run_test(input int id, input int cycles, input int v_pct,
                          input int r_pct, input int d_mode);
    in_mask_t taken;
    valid_pct = v_pct;
    ready_pct = r_pct;
    dest_mode = d_mode;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      taken = yumi;
      @(posedge clk);
      #1;
      test_id = id;
      update_sources(taken);
      test_end = (c == cycles - 1);
    end
  endtask

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  initial begin
    void'($urandom(22));
    rst_n     = 1'b0;
    src_valid = '0;
    src_flit  = '0;
    rcv_ready = '0;
    test_id   = 0;
    test_end  = 1'b0;
    valid_pct = 0;
    ready_pct = 0;
    dest_mode = DEST_RANDOM;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_test(1, LEN_IDLE, 0, 100, DEST_RANDOM);
    // contention right after reset exposes the initial pointer.
    run_test(2, LEN_FAIR, 100, 100, DEST_ZERO);
    run_test(3, LEN_UNCONT, 80, 100, DEST_OWN);
    run_test(4, LEN_BACKP, 70, 30, DEST_RANDOM);
    run_test(5, LEN_RANDOM, 50, 60, DEST_RANDOM);
    // the checker closes the last test at this edge.
    @(negedge clk);
    #1;
    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // hard stop in case the run never completes.
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/xbar_flit_pkg.sv
hw/xbar_ctrl_pkg.sv
hw/xbar_route_decode.sv
hw/xbar_rr_arbiter.sv
hw/xbar_output_execute.sv
hw/xbar_yumi_result.sv
hw/xbar_router.sv
verification/xbar_checker.sv
verification/xbar_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crossbar router testbench with Verilator.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module xbar_tb \
  --Mdir obj_dir \
  -o xbar_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/xbar_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
